// ==== src/fetch_pkg.sv ====
package fetch_pkg;

    // 32-bit address or instruction word
    typedef logic [31:0] word_t;

    // bus line, lower word sits at the line-aligned address
    typedef logic [63:0] line_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t instr;
        logic  bad_addr;
    } fetch_slot_t;

    // index 1 is the older instruction, index 0 the younger one
    typedef fetch_slot_t [1:0] slot_pair_t;

    // request in flight between the PC and the returned line
    typedef struct packed {
        logic  valid;
        word_t pc;
        logic  bad_addr;
    } f1_entry_t;

    localparam word_t RESET_PC  = 32'hbfc0_0000;
    localparam word_t EXC_ENTRY = 32'hbfc0_0380;

endpackage

// ==== src/redirect_if.sv ====
`timescale 1ns/1ps

// one-cycle redirect pulses, no acknowledge
interface redirect_if;
    logic             branch_taken;
    fetch_pkg::word_t branch_target;
    logic             exc_taken;
    logic             eret;
    fetch_pkg::word_t epc;

    modport source (
        output branch_taken, branch_target, exc_taken, eret, epc
    );

    modport sink (
        input branch_taken, branch_target, exc_taken, eret, epc
    );

endinterface

// ==== src/pipe_reg.sv ====
`timescale 1ns/1ps

module pipe_reg #(
    parameter type T = logic
) (
    input  logic clk,
    input  logic reset,
    input  logic en,
    input  logic flush,
    input  T     d,
    output T     q
);

    // flush wins over enable
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            q <= '0;
        end else if (en) begin
            q <= d;
        end
    end

endmodule

// ==== src/pc_gen.sv ====
`timescale 1ns/1ps

module pc_gen #(
    parameter fetch_pkg::word_t reset_pc  = fetch_pkg::RESET_PC,
    parameter fetch_pkg::word_t exc_entry = fetch_pkg::EXC_ENTRY
) (
    input  logic                 clk,
    input  logic                 reset,
    redirect_if.sink             redir,
    input  logic                 hold,
    input  logic                 ibus_addr_ok,
    output logic                 ibus_valid,
    output fetch_pkg::word_t     ibus_addr,
    output fetch_pkg::f1_entry_t f1_next
);

    fetch_pkg::word_t pc;
    fetch_pkg::word_t pc_succ;
    fetch_pkg::word_t pc_nxt;
    fetch_pkg::word_t saved_pc;
    logic             saved_valid;
    logic             redirect_now;
    logic             misaligned;
    logic             fetch_ok;
    logic             stall_f;

    assign redirect_now = redir.exc_taken || redir.eret || redir.branch_taken;
    assign misaligned   = pc[1:0] != 2'b00;

    // pc in the upper word only yields one slot
    assign pc_succ = pc[2] ? pc + 32'd4 : pc + 32'd8;

    // exception entry beats everything, even a saved target
    always_comb begin
        if (redir.exc_taken) begin
            pc_nxt = exc_entry;
        end else if (saved_valid) begin
            pc_nxt = saved_pc;
        end else if (redir.eret) begin
            pc_nxt = redir.epc;
        end else if (redir.branch_taken) begin
            pc_nxt = redir.branch_target;
        end else begin
            pc_nxt = pc_succ;
        end
    end

    // no fetch on the wrong path or while downstream is held
    assign fetch_ok   = !hold && !redirect_now && !saved_valid;
    assign ibus_valid = !reset && fetch_ok && !misaligned;
    assign ibus_addr  = pc;

    assign stall_f = (ibus_valid && !ibus_addr_ok) || hold;

    // a bad address goes down the pipe without a bus request
    assign f1_next.valid    = (ibus_valid && ibus_addr_ok) || (fetch_ok && misaligned);
    assign f1_next.pc       = pc;
    assign f1_next.bad_addr = misaligned;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= reset_pc;
        end else if (!stall_f) begin
            pc <= pc_nxt;
        end
    end

    // redirect seen during a stall waits here until the stall ends
    always_ff @(posedge clk) begin
        if (reset) begin
            saved_valid <= 1'b0;
        end else if (stall_f && redirect_now) begin
            saved_valid <= 1'b1;
        end else if (!stall_f) begin
            saved_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (stall_f && redirect_now) begin
            saved_pc <= pc_nxt;
        end
    end

    req_aligned_a: assert property (@(posedge clk) disable iff (reset)
        ibus_valid |-> ibus_addr[1:0] == 2'b00);

    // a pulse kills the current pc, so it must never reach the bus
    no_req_on_redirect_a: assert property (@(posedge clk) disable iff (reset)
        redirect_now |-> !ibus_valid);

endmodule

// ==== src/instr_split.sv ====
`timescale 1ns/1ps

module instr_split (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 hold,
    input  fetch_pkg::f1_entry_t f1,
    input  fetch_pkg::line_t     ibus_data,
    output fetch_pkg::slot_pair_t slots_next
);

    fetch_pkg::line_t line_hold;
    fetch_pkg::line_t line;
    logic             hold_valid;
    logic             slot0_ok;

    // bus data lasts one cycle, keep it while the output is held
    always_ff @(posedge clk) begin
        if (reset) begin
            hold_valid <= 1'b0;
        end else if (hold && !hold_valid && f1.valid) begin
            hold_valid <= 1'b1;
        end else if (!hold) begin
            hold_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (hold && !hold_valid && f1.valid) begin
            line_hold <= ibus_data;
        end
    end

    assign line = hold_valid ? line_hold : ibus_data;

    // second slot only when the pc is line aligned
    assign slot0_ok = f1.valid && !f1.pc[2] && !f1.bad_addr;

    always_comb begin
        slots_next[1].valid    = f1.valid;
        slots_next[1].pc       = f1.pc;
        slots_next[1].bad_addr = f1.bad_addr;
        if (f1.bad_addr) begin
            slots_next[1].instr = '0;
        end else if (f1.pc[2]) begin
            slots_next[1].instr = line[63:32];
        end else begin
            slots_next[1].instr = line[31:0];
        end

        slots_next[0].valid    = slot0_ok;
        slots_next[0].bad_addr = 1'b0;
        slots_next[0].pc       = slot0_ok ? f1.pc + 32'd4 : '0;
        slots_next[0].instr    = slot0_ok ? line[63:32] : '0;
    end

    slot_order_a: assert property (@(posedge clk) disable iff (reset)
        slots_next[0].valid |-> slots_next[1].valid && !slots_next[1].bad_addr);

endmodule

// ==== src/fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top #(
    parameter fetch_pkg::word_t reset_pc  = fetch_pkg::RESET_PC,
    parameter fetch_pkg::word_t exc_entry = fetch_pkg::EXC_ENTRY
) (
    input  logic                  clk,
    input  logic                  reset,
    output logic                  ibus_valid,
    output fetch_pkg::word_t      ibus_addr,
    input  logic                  ibus_addr_ok,
    input  fetch_pkg::line_t      ibus_data,
    input  logic                  hold,
    input  logic                  branch_taken,
    input  fetch_pkg::word_t      branch_target,
    input  logic                  exc_taken,
    input  logic                  eret,
    input  fetch_pkg::word_t      epc,
    output fetch_pkg::slot_pair_t slots
);

    fetch_pkg::f1_entry_t  f1_next;
    fetch_pkg::f1_entry_t  f1;
    fetch_pkg::slot_pair_t slots_next;
    logic                  flush_f1;

    redirect_if redir ();

    assign redir.branch_taken  = branch_taken;
    assign redir.branch_target = branch_target;
    assign redir.exc_taken     = exc_taken;
    assign redir.eret          = eret;
    assign redir.epc           = epc;

    // any redirect kills the request in flight
    assign flush_f1 = branch_taken || exc_taken || eret;

    pc_gen #(
        .reset_pc  (reset_pc),
        .exc_entry (exc_entry)
    ) pc_gen_i (
        .clk          (clk),
        .reset        (reset),
        .redir        (redir.sink),
        .hold         (hold),
        .ibus_addr_ok (ibus_addr_ok),
        .ibus_valid   (ibus_valid),
        .ibus_addr    (ibus_addr),
        .f1_next      (f1_next)
    );

    pipe_reg #(.T(fetch_pkg::f1_entry_t)) f1_reg (
        .clk   (clk),
        .reset (reset),
        .en    (!hold),
        .flush (flush_f1),
        .d     (f1_next),
        .q     (f1)
    );

    instr_split split_i (
        .clk        (clk),
        .reset      (reset),
        .hold       (hold),
        .f1         (f1),
        .ibus_data  (ibus_data),
        .slots_next (slots_next)
    );

    // output stays frozen while held, so never flushed
    pipe_reg #(.T(fetch_pkg::slot_pair_t)) out_reg (
        .clk   (clk),
        .reset (reset),
        .en    (!hold),
        .flush (1'b0),
        .d     (slots_next),
        .q     (slots)
    );

endmodule

// ==== tb/fetch_ref.svh ====
`ifndef FETCH_REF_SVH
`define FETCH_REF_SVH

// memory contents, a fixed hash of the byte address
function automatic fetch_pkg::word_t mem_word(input fetch_pkg::word_t addr);
    fetch_pkg::word_t h;
    h = (addr ^ 32'h5bd1_e995) * 32'h9e37_79b1;
    h = h ^ (h >> 15);
    return h ^ {addr[15:0], addr[31:16]};
endfunction

// line holding addr, lower word at the aligned address
function automatic fetch_pkg::line_t mem_line(input fetch_pkg::word_t addr);
    return {mem_word({addr[31:3], 3'b100}), mem_word({addr[31:3], 3'b000})};
endfunction

// start of the next line with the byte offset kept
// so the upper word of a line yields one slot only
function automatic fetch_pkg::word_t pc_succ(input fetch_pkg::word_t pc);
    return {pc[31:3] + 29'd1, 1'b0, pc[1:0]};
endfunction

// exception first, then eret, then branch
function automatic fetch_pkg::word_t redirect_target(input fetch_pkg::word_t tgt,
        input logic exc, input logic er, input fetch_pkg::word_t ep);
    if (exc) begin
        return fetch_pkg::EXC_ENTRY;
    end
    return er ? ep : tgt;
endfunction

function automatic fetch_pkg::slot_pair_t expect_pair(input fetch_pkg::word_t pc);
    fetch_pkg::slot_pair_t p;
    logic                  bad;
    bad = pc[1:0] != 2'b00;
    p = '0;
    p[1].valid    = 1'b1;
    p[1].pc       = pc;
    p[1].bad_addr = bad;
    p[1].instr    = bad ? 32'h0 : mem_word(pc);
    if (!bad && !pc[2]) begin
        p[0].valid = 1'b1;
        p[0].pc    = pc + 32'd4;
        p[0].instr = mem_word(pc + 32'd4);
    end
    return p;
endfunction

`endif

// ==== tb/fetch_tb.sv ====
`timescale 1ns/1ps

module fetch_tb;

    localparam int plain_len      = 40;
    localparam int random_len     = 400;
    localparam int branch_count   = 12;
    localparam int redirect_count = branch_count + 4;
    localparam int redirect_len   = 30;
    localparam int total_len      = plain_len + random_len + redirect_count * redirect_len;
    localparam int min_pairs      = 150;

    logic                  clk = 1'b0;
    logic                  reset;
    logic                  ibus_valid;
    fetch_pkg::word_t      ibus_addr;
    logic                  ibus_addr_ok;
    fetch_pkg::line_t      ibus_data = '0;
    logic                  hold;
    logic                  branch_taken;
    fetch_pkg::word_t      branch_target;
    logic                  exc_taken;
    logic                  eret;
    fetch_pkg::word_t      epc;
    fetch_pkg::slot_pair_t slots;

    integer                seed;
    int                    hold_left;
    int                    targets_sent;
    fetch_pkg::word_t      pending_target;
    int                    targets_seen = 0;
    int                    pairs_seen = 0;
    logic                  first_pair = 1'b1;
    fetch_pkg::word_t      last_pc = '0;
    logic                  bus_accept = 1'b0;
    fetch_pkg::word_t      bus_addr = '0;
    logic                  reset_prev = 1'b1;
    logic                  hold_prev = 1'b0;
    fetch_pkg::slot_pair_t slots_prev = '0;

    `include "fetch_ref.svh"

    fetch_top dut_i (
        .clk           (clk),
        .reset         (reset),
        .ibus_valid    (ibus_valid),
        .ibus_addr     (ibus_addr),
        .ibus_addr_ok  (ibus_addr_ok),
        .ibus_data     (ibus_data),
        .hold          (hold),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .exc_taken     (exc_taken),
        .eret          (eret),
        .epc           (epc),
        .slots         (slots)
    );

    always #5 clk = ~clk;

    task automatic abort_run();
        $display("tests failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR %s: got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_addr(input string name, input fetch_pkg::word_t got,
                              input fetch_pkg::word_t exp);
        if (got !== exp) begin
            $display("ERROR %s: got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    // an empty slot is compared on its valid bit only
    task automatic check_pair(input string name, input fetch_pkg::slot_pair_t got,
                              input fetch_pkg::slot_pair_t exp);
        fetch_pkg::slot_pair_t seen;
        fetch_pkg::slot_pair_t want;
        int                    i;
        seen = got;
        want = exp;
        for (i = 0; i < 2; i++) begin
            if (!exp[i].valid) begin
                seen[i]       = '0;
                seen[i].valid = got[i].valid;
                want[i]       = '0;
            end
        end
        if (seen !== want) begin
            $display("ERROR %s: got %h expected %h", name, seen, want);
            abort_run();
        end
    endtask

    // successor of the last pair, or the redirect target still owed
    task automatic check_stream(input fetch_pkg::slot_pair_t got);
        fetch_pkg::word_t p;
        p = got[1].pc;
        if (targets_seen < targets_sent && p == pending_target) begin
            targets_seen = targets_seen + 1;
        end else if (first_pair) begin
            check_addr("slots[1].pc", p, fetch_pkg::RESET_PC);
        end else begin
            check_addr("slots[1].pc", p, pc_succ(last_pc));
        end
        first_pair = 1'b0;
        last_pc    = p;
        pairs_seen = pairs_seen + 1;
        check_pair("slots", got, expect_pair(p));
    endtask

    task automatic random_step();
        int r;
        @(posedge clk);
        #1;
        branch_taken = 1'b0;
        exc_taken    = 1'b0;
        eret         = 1'b0;
        r = $random(seed);
        ibus_addr_ok = (r & 3) != 0;
        if (hold_left > 0) begin
            hold      = 1'b1;
            hold_left = hold_left - 1;
        end else if ((r & 32'hf0) == 0) begin
            hold      = 1'b1;
            hold_left = (r >> 8) & 3;
        end else begin
            hold = 1'b0;
        end
    endtask

    task automatic send_redirect(input logic br, input fetch_pkg::word_t tgt, input logic exc,
                                 input logic er, input fetch_pkg::word_t ep, input logic in_hold);
        @(posedge clk);
        #1;
        branch_taken   = br;
        branch_target  = tgt;
        exc_taken      = exc;
        eret           = er;
        epc            = ep;
        hold           = in_hold;
        hold_left      = in_hold ? 2 : 0;
        pending_target = redirect_target(tgt, exc, er, ep);
        targets_sent   = targets_sent + 1;
        while (targets_seen < targets_sent) begin
            random_step();
        end
        repeat (4 + ($random(seed) & 15)) begin
            random_step();
        end
    endtask

    // each target gets a 1 MB region of its own
    function automatic fetch_pkg::word_t far_target(input int k);
        return 32'h8000_0000 | (k << 20) | ($random(seed) & 32'h0000_fffc);
    endfunction

    // bus model, line valid in the cycle after acceptance only
    always @(negedge clk) begin
        bus_accept = !reset && ibus_valid && ibus_addr_ok;
        bus_addr   = ibus_addr;
        // no request in reset, while held or in a redirect cycle
        if (reset || hold || branch_taken || exc_taken || eret) begin
            check_bit("ibus_valid", ibus_valid, 1'b0);
        end
        if (!reset && ibus_valid) begin
            check_addr("ibus_addr", ibus_addr, ibus_addr & 32'hffff_fffc);
        end
    end

    always @(posedge clk) begin
        #1;
        ibus_data = bus_accept ? mem_line(bus_addr) : ~mem_line(bus_addr);
    end

    // hold and reset seen at the previous negedge governed the edge in between
    always @(negedge clk) begin
        if (!reset_prev) begin
            if (hold_prev) begin
                check_pair("slots", slots, slots_prev);
            end else if (slots[1].valid) begin
                check_stream(slots);
            end
        end
        reset_prev = reset;
        hold_prev  = hold;
        slots_prev = slots;
    end

    initial begin
        repeat (total_len * 20) @(posedge clk);
        $display("timeout after %0d cycles, the fetch stream stopped", total_len * 20);
        abort_run();
    end

    initial begin
        int k;
        seed          = 32'hdd0f3a06;
        hold_left     = 0;
        targets_sent  = 0;
        reset         = 1'b1;
        hold          = 1'b0;
        ibus_addr_ok  = 1'b0;
        branch_taken  = 1'b0;
        branch_target = '0;
        exc_taken     = 1'b0;
        eret          = 1'b0;
        epc           = '0;
        repeat (4) @(posedge clk);
        #1;
        reset        = 1'b0;
        ibus_addr_ok = 1'b1;
        check_pair("slots", slots, '0);

        repeat (plain_len) @(posedge clk);
        repeat (random_len) begin
            random_step();
        end

        // odd branches arrive while the output is held
        for (k = 0; k < branch_count; k++) begin
            send_redirect(1'b1, far_target(k), 1'b0, 1'b0, '0, k[0]);
        end
        send_redirect(1'b1, far_target(100), 1'b1, 1'b0, '0, 1'b0);
        send_redirect(1'b0, '0, 1'b0, 1'b1, far_target(101), 1'b0);
        // misaligned stream, then back to an aligned one under hold
        send_redirect(1'b1, far_target(102) | 32'h2, 1'b0, 1'b0, '0, 1'b0);
        send_redirect(1'b1, far_target(103), 1'b0, 1'b0, '0, 1'b1);

        if (pairs_seen >= min_pairs) begin
            $display("all tests passed");
            $finish;
        end else begin
            $display("only %0d slot pairs were checked", pairs_seen);
            abort_run();
        end
    end

endmodule

// ==== build.f ====
+incdir+tb
src/fetch_pkg.sv
src/redirect_if.sv
src/pipe_reg.sv
src/pc_gen.sv
src/instr_split.sv
src/fetch_top.sv
tb/fetch_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module fetch_tb -f build.f -o fetch_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/fetch_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

printf '%s\n' "$out" | grep -qx "all tests passed" || exit 1
exit 0
